//--- verilog/rv_macros.svh
// Widths, reset address and opcode values of the RV32I core
// Opcode values are instruction bits 6 to 2; bits 1 and 0 are never checked
`ifndef RV_MACROS_SVH
`define RV_MACROS_SVH

`define RV_XLEN       32
`define RV_NREGS      32
`define RV_REG_BITS   5
`define RV_RESET_ADDR 32'h0000_0000

// Major opcodes, one per instruction class
`define RV_OP_LOAD    5'b00000
`define RV_OP_ALUIMM  5'b00100
`define RV_OP_AUIPC   5'b00101
`define RV_OP_STORE   5'b01000
`define RV_OP_ALUREG  5'b01100
`define RV_OP_LUI     5'b01101
`define RV_OP_BRANCH  5'b11000
`define RV_OP_JALR    5'b11001
`define RV_OP_JAL     5'b11011

`endif

//--- verilog/rv_pkg.sv
// Shared types of the core: FSM states, memory port and decoded instruction
// Memory port is word wide; byte lanes are selected by the mask
`include "rv_macros.svh"

package rv_pkg;

   // One-hot states of the fetch/execute FSM
   typedef enum logic [3:0] {
      FETCH      = 4'b0001,
      WAIT_INSTR = 4'b0010,
      EXECUTE    = 4'b0100,
      WAIT_MEM   = 4'b1000
   } state_t;

   // Core to memory, 70 bits
   typedef struct packed {
      logic [`RV_XLEN-1:0] addr;
      logic [`RV_XLEN-1:0] wdata;
      logic [3:0]          mask;
      logic                rstrb;
      logic                wstrb;
   } memReq_t;

   // Memory to core, 34 bits
   typedef struct packed {
      logic [`RV_XLEN-1:0] rdata;
      logic                rbusy;
      logic                wbusy;
   } memRsp_t;

   typedef struct packed {
      // Class flags
      logic isLoad;
      logic isAluImm;
      logic isAuipc;
      logic isStore;
      logic isAluReg;
      logic isLui;
      logic isBranch;
      logic isJalr;
      logic isJal;
      logic isAlu;
      logic isMem;
      logic [`RV_REG_BITS-1:0] rd;
      logic [`RV_REG_BITS-1:0] rs1Id;
      logic [`RV_REG_BITS-1:0] rs2Id;
      // funct3Is[n] set when funct3 equals n
      logic [7:0] funct3Is;
      // Bit 30, SUB or SRA
      logic subSra;
      // Bit 5, register form of the ALU op
      logic regOp;
      logic [`RV_XLEN-1:0] iImm;
      logic [`RV_XLEN-1:0] sImm;
      logic [`RV_XLEN-1:0] bImm;
      logic [`RV_XLEN-1:0] jImm;
      logic [`RV_XLEN-1:0] uImm;
   } decoded_t;

endpackage

//--- verilog/rv_decoder.sv
// Combinational decode of the latched instruction word
// SYSTEM and unknown opcodes set no class flag and so act as no-ops
`timescale 1ns/1ps
`include "rv_macros.svh"

module rv_decoder (
   input  logic [31:2]       instr,
   output rv_pkg::decoded_t  dec
);

   logic [4:0] opcode;

   assign opcode = instr[6:2];

   always_comb begin
      // Class flags straight from the major opcode
      dec.isLoad   = (opcode == `RV_OP_LOAD);
      dec.isAluImm = (opcode == `RV_OP_ALUIMM);
      dec.isAuipc  = (opcode == `RV_OP_AUIPC);
      dec.isStore  = (opcode == `RV_OP_STORE);
      dec.isAluReg = (opcode == `RV_OP_ALUREG);
      dec.isLui    = (opcode == `RV_OP_LUI);
      dec.isBranch = (opcode == `RV_OP_BRANCH);
      dec.isJalr   = (opcode == `RV_OP_JALR);
      dec.isJal    = (opcode == `RV_OP_JAL);
      dec.isAlu    = dec.isAluImm | dec.isAluReg;
      dec.isMem    = dec.isLoad | dec.isStore;

      dec.rd    = instr[11:7];
      dec.rs1Id = instr[19:15];
      dec.rs2Id = instr[24:20];

      // One-hot funct3 keeps the ALU and branch muxes flat
      dec.funct3Is = 8'b0000_0001 << instr[14:12];
      dec.subSra   = instr[30];
      // ADDI has an immediate bit at 30, so SUB also needs bit 5
      dec.regOp    = instr[5];

      // Immediates, all sign extended from bit 31
      dec.iImm = {{21{instr[31]}}, instr[30:20]};
      dec.sImm = {{21{instr[31]}}, instr[30:25], instr[11:7]};
      dec.bImm = {{20{instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};
      dec.jImm = {{12{instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};
      dec.uImm = {instr[31:12], 12'b0};
   end

endmodule

//--- verilog/rv_alu.sv
// Shared adder, 33-bit compare, one shifter for both directions
// Fully combinational; operands must be stable through EXECUTE and WAIT_MEM
`timescale 1ns/1ps
`include "rv_macros.svh"

module rv_alu (
   input  rv_pkg::decoded_t     dec,
   input  logic [`RV_XLEN-1:0]  rs1,
   input  logic [`RV_XLEN-1:0]  rs2,
   input  logic [`RV_XLEN-1:0]  pc,
   output logic [`RV_XLEN-1:0]  aluSum,
   output logic [`RV_XLEN-1:0]  aluOut,
   output logic                 predicate
);

   logic [`RV_XLEN-1:0] aluIn1;
   logic [`RV_XLEN-1:0] aluIn2;
   logic [`RV_XLEN-1:0] plusIn1;
   logic [`RV_XLEN-1:0] plusIn2;
   logic [`RV_XLEN:0]   aluMinus;
   logic                lt;
   logic                ltu;
   logic                eq;
   logic [`RV_XLEN-1:0] shiftIn;
   logic signed [`RV_XLEN:0] shiftExt;
   logic signed [`RV_XLEN:0] shiftFull;
   logic [`RV_XLEN-1:0] shifter;
   logic [`RV_XLEN-1:0] leftShift;

   function automatic logic [`RV_XLEN-1:0] revBits(input logic [`RV_XLEN-1:0] v);
      logic [`RV_XLEN-1:0] r;
      for (int i = 0; i < `RV_XLEN; i++) begin
         r[i] = v[`RV_XLEN-1-i];
      end
      return r;
   endfunction

   // Compare and logic ops see rs2 for register forms and branches
   assign aluIn1 = rs1;
   assign aluIn2 = (dec.isAluReg | dec.isBranch) ? rs2 : dec.iImm;

   // Adder serves ADD/ADDI, load/store addresses, AUIPC and jump targets
   assign plusIn1 = (dec.isAlu | dec.isMem | dec.isJalr) ? rs1 : pc;
   assign plusIn2 = dec.isStore  ? dec.sImm :
                    dec.isJal    ? dec.jImm :
                    dec.isAuipc  ? dec.uImm :
                    dec.isBranch ? dec.bImm :
                    dec.isAluReg ? rs2      : dec.iImm;
   assign aluSum  = plusIn1 + plusIn2;

   // Borrow out of the 33-bit difference is the unsigned less-than
   assign aluMinus = {1'b0, aluIn1} - {1'b0, aluIn2};
   assign ltu      = aluMinus[`RV_XLEN];
   // Differing signs decide the signed compare on their own
   assign lt = (aluIn1[`RV_XLEN-1] ^ aluIn2[`RV_XLEN-1]) ? aluIn1[`RV_XLEN-1] : ltu;
   assign eq = (aluMinus[`RV_XLEN-1:0] == '0);

   // SLL reverses the bits, shifts right, then reverses back
   assign shiftIn   = dec.funct3Is[1] ? revBits(aluIn1) : aluIn1;
   // Extra top bit carries the sign only for SRA
   assign shiftExt  = {dec.subSra & aluIn1[`RV_XLEN-1], shiftIn};
   assign shiftFull = shiftExt >>> aluIn2[4:0];
   assign shifter   = shiftFull[`RV_XLEN-1:0];
   assign leftShift = revBits(shifter);

   always_comb begin
      unique case (1'b1)
         dec.funct3Is[0]: aluOut = (dec.subSra & dec.regOp) ?
                                   aluMinus[`RV_XLEN-1:0] : aluSum;
         dec.funct3Is[1]: aluOut = leftShift;
         dec.funct3Is[2]: aluOut = {{(`RV_XLEN-1){1'b0}}, lt};
         dec.funct3Is[3]: aluOut = {{(`RV_XLEN-1){1'b0}}, ltu};
         dec.funct3Is[4]: aluOut = aluIn1 ^ aluIn2;
         dec.funct3Is[5]: aluOut = shifter;
         dec.funct3Is[6]: aluOut = aluIn1 | aluIn2;
         default:         aluOut = aluIn1 & aluIn2;
      endcase
   end

   // Branch conditions, funct3 values 2 and 3 are unused
   assign predicate = dec.funct3Is[0] &  eq  |
                      dec.funct3Is[1] & ~eq  |
                      dec.funct3Is[4] &  lt  |
                      dec.funct3Is[5] & ~lt  |
                      dec.funct3Is[6] &  ltu |
                      dec.funct3Is[7] & ~ltu;

endmodule

//--- verilog/rv_regfile.sv
// 32 x 32 register file, x0 reads as zero and ignores writes
// Operands are read from the fetched word's indices when capture is high
`timescale 1ns/1ps
`include "rv_macros.svh"

module rv_regfile (
   input  logic                     clk,
   input  logic                     resetn,
   input  logic                     capture,
   input  logic [`RV_REG_BITS-1:0]  rs1Id,
   input  logic [`RV_REG_BITS-1:0]  rs2Id,
   input  logic                     wbEn,
   input  logic [`RV_REG_BITS-1:0]  rdId,
   input  logic [`RV_XLEN-1:0]      wbData,
   output logic [`RV_XLEN-1:0]      rs1,
   output logic [`RV_XLEN-1:0]      rs2
);

   logic [`RV_XLEN-1:0] regs [`RV_NREGS];

   always_ff @(posedge clk) begin
      if (wbEn && rdId != '0) begin
         regs[rdId] <= wbData;
      end
      // Entry 0 is never written, so zero is forced on the read side
      if (capture) begin
         rs1 <= (rs1Id == '0) ? '0 : regs[rs1Id];
         rs2 <= (rs2Id == '0) ? '0 : regs[rs2Id];
      end
   end

   // A capture in the write cycle would read the stale value
   assert property (@(posedge clk) disable iff (!resetn) !(wbEn && capture))
      else $error("register write during operand capture");

endmodule

//--- verilog/rv_lsu.sv
// Byte and halfword lane handling around a word-wide memory
// Misaligned halfword and word accesses are not detected
`timescale 1ns/1ps
`include "rv_macros.svh"

module rv_lsu (
   input  logic [2:0]           funct3,
   input  logic [1:0]           addr,
   input  logic [`RV_XLEN-1:0]  rs2,
   input  logic [`RV_XLEN-1:0]  rdata,
   output logic [`RV_XLEN-1:0]  loadData,
   output logic [`RV_XLEN-1:0]  storeData,
   output logic [3:0]           storeMask
);

   logic        byteAccess;
   logic        halfAccess;
   logic [15:0] loadHalf;
   logic [7:0]  loadByte;
   logic        loadSign;

   // funct3[1:0] gives the size, funct3[2] turns off sign extension
   assign byteAccess = (funct3[1:0] == 2'b00);
   assign halfAccess = (funct3[1:0] == 2'b01);

   // Halfword lane first, then the byte within it
   assign loadHalf = addr[1] ? rdata[31:16] : rdata[15:0];
   assign loadByte = addr[0] ? loadHalf[15:8] : loadHalf[7:0];
   assign loadSign = ~funct3[2] & (byteAccess ? loadByte[7] : loadHalf[15]);

   assign loadData = byteAccess ? {{24{loadSign}}, loadByte} :
                     halfAccess ? {{16{loadSign}}, loadHalf} :
                                  rdata;

   // Low bytes of rs2 copied into every lane they may land in
   assign storeData[7:0]   = rs2[7:0];
   assign storeData[15:8]  = addr[0] ? rs2[7:0] : rs2[15:8];
   assign storeData[23:16] = addr[1] ? rs2[7:0] : rs2[23:16];
   assign storeData[31:24] = addr[0] ? rs2[7:0] :
                             addr[1] ? rs2[15:8] : rs2[31:24];

   always_comb begin
      if (byteAccess) begin
         storeMask = 4'b0001 << addr;
      end else if (halfAccess) begin
         storeMask = addr[1] ? 4'b1100 : 4'b0011;
      end else begin
         storeMask = 4'b1111;
      end
   end

endmodule

//--- verilog/rv_control.sv
// FSM, PC and instruction register of the multi-cycle core
// Every load and store waits for memory idle before the next fetch
// Non-memory instructions start the next fetch from EXECUTE
`timescale 1ns/1ps
`include "rv_macros.svh"

module rv_control (
   input  logic                 clk,
   input  logic                 resetn,
   input  rv_pkg::memRsp_t      memRsp,
   input  rv_pkg::decoded_t     dec,
   input  logic [`RV_XLEN-1:0]  aluSum,
   input  logic [`RV_XLEN-1:0]  aluOut,
   input  logic                 predicate,
   input  logic [`RV_XLEN-1:0]  loadData,
   input  logic [`RV_XLEN-1:0]  storeData,
   input  logic [3:0]           storeMask,
   output logic [31:2]          instr,
   output logic [`RV_XLEN-1:0]  pc,
   output logic                 rs1Capture,
   output logic                 wbEn,
   output logic [`RV_XLEN-1:0]  wbData,
   output rv_pkg::memReq_t      memReq
);

   rv_pkg::state_t state;

   logic inFetch;
   logic inWaitInstr;
   logic inExecute;
   logic inWaitMem;
   logic jump;
   logic [`RV_XLEN-1:0] pcPlus4;
   logic [`RV_XLEN-1:0] pcNext;

   assign inFetch     = (state == rv_pkg::FETCH);
   assign inWaitInstr = (state == rv_pkg::WAIT_INSTR);
   assign inExecute   = (state == rv_pkg::EXECUTE);
   assign inWaitMem   = (state == rv_pkg::WAIT_MEM);

   // Jump targets come from the adder with bit 0 cleared
   assign jump    = dec.isJal | dec.isJalr | (dec.isBranch & predicate);
   assign pcPlus4 = pc + `RV_XLEN'd4;
   assign pcNext  = jump ? {aluSum[`RV_XLEN-1:1], 1'b0} : pcPlus4;

   // Instruction accepted on the first non-busy cycle
   assign rs1Capture = inWaitInstr & ~memRsp.rbusy;

   always_ff @(posedge clk) begin
      if (!resetn) begin
         // Start by waiting for the memory to go idle
         state <= rv_pkg::WAIT_MEM;
         pc    <= `RV_RESET_ADDR;
         // No class matches and rd is x0
         instr <= 30'd1;
      end else begin
         unique case (1'b1)
            inWaitInstr: begin
               if (!memRsp.rbusy) begin
                  instr <= memRsp.rdata[31:2];
                  state <= rv_pkg::EXECUTE;
               end
            end
            inExecute: begin
               pc    <= pcNext;
               state <= dec.isMem ? rv_pkg::WAIT_MEM : rv_pkg::WAIT_INSTR;
            end
            inWaitMem: begin
               if (!memRsp.rbusy && !memRsp.wbusy) begin
                  state <= rv_pkg::FETCH;
               end
            end
            default: begin
               state <= rv_pkg::WAIT_INSTR;
            end
         endcase
      end
   end

   // Loads write in WAIT_MEM once the data is in and the rest write in EXECUTE
   assign wbEn = inExecute & (dec.isAlu | dec.isLui | dec.isAuipc | dec.isJal | dec.isJalr) |
                 inWaitMem & dec.isLoad & ~memRsp.rbusy;

   always_comb begin
      if (dec.isLui) begin
         wbData = dec.uImm;
      end else if (dec.isAlu) begin
         wbData = aluOut;
      end else if (dec.isAuipc) begin
         wbData = aluSum;
      end else if (dec.isJal || dec.isJalr) begin
         // pc still holds the jump's own address here
         wbData = pcPlus4;
      end else begin
         wbData = loadData;
      end
   end

   always_comb begin
      // Address is pc in a fetch and pcNext in an overlapped fetch, or else the data address
      if (inFetch || inWaitInstr) begin
         memReq.addr = pc;
      end else if (inExecute && !dec.isMem) begin
         memReq.addr = pcNext;
      end else begin
         memReq.addr = aluSum;
      end
      memReq.wdata = storeData;
      memReq.mask  = ((inExecute || inWaitMem) && dec.isMem) ? storeMask : 4'b1111;
      memReq.rstrb = inFetch | (inExecute & ~dec.isStore);
      memReq.wstrb = inExecute & dec.isStore;
   end

   assert property (@(posedge clk) disable iff (!resetn) $onehot(state))
      else $error("FSM state not one-hot");

   assert property (@(posedge clk) disable iff (!resetn) !(memReq.rstrb && memReq.wstrb))
      else $error("read and write strobes raised together");

endmodule

//--- verilog/rv_core.sv
// Top level of the RV32I core, one word-wide strobe/busy memory port
// No interrupts and no CSRs; SYSTEM instructions do nothing
`timescale 1ns/1ps
`include "rv_macros.svh"

module rv_core (
   input  logic             clk,
   input  logic             resetn,
   output rv_pkg::memReq_t  memReq,
   input  rv_pkg::memRsp_t  memRsp
);

   rv_pkg::decoded_t dec;

   logic [31:2]         instr;
   logic [`RV_XLEN-1:0] pc;
   logic [`RV_XLEN-1:0] rs1;
   logic [`RV_XLEN-1:0] rs2;
   logic [`RV_XLEN-1:0] aluSum;
   logic [`RV_XLEN-1:0] aluOut;
   logic                predicate;
   logic [`RV_XLEN-1:0] loadData;
   logic [`RV_XLEN-1:0] storeData;
   logic [3:0]          storeMask;
   logic                rs1Capture;
   logic                wbEn;
   logic [`RV_XLEN-1:0] wbData;

   rv_control control_i (
      .clk        (clk),
      .resetn     (resetn),
      .memRsp     (memRsp),
      .dec        (dec),
      .aluSum     (aluSum),
      .aluOut     (aluOut),
      .predicate  (predicate),
      .loadData   (loadData),
      .storeData  (storeData),
      .storeMask  (storeMask),
      .instr      (instr),
      .pc         (pc),
      .rs1Capture (rs1Capture),
      .wbEn       (wbEn),
      .wbData     (wbData),
      .memReq     (memReq)
   );

   rv_decoder decoder_i (
      .instr (instr),
      .dec   (dec)
   );

   rv_alu alu_i (
      .dec       (dec),
      .rs1       (rs1),
      .rs2       (rs2),
      .pc        (pc),
      .aluSum    (aluSum),
      .aluOut    (aluOut),
      .predicate (predicate)
   );

   // Read indices come from the word arriving on the bus
   rv_regfile regfile_i (
      .clk     (clk),
      .resetn  (resetn),
      .capture (rs1Capture),
      .rs1Id   (memRsp.rdata[19:15]),
      .rs2Id   (memRsp.rdata[24:20]),
      .wbEn    (wbEn),
      .rdId    (dec.rd),
      .wbData  (wbData),
      .rs1     (rs1),
      .rs2     (rs2)
   );

   rv_lsu lsu_i (
      .funct3    (instr[14:12]),
      .addr      (aluSum[1:0]),
      .rs2       (rs2),
      .rdata     (memRsp.rdata),
      .loadData  (loadData),
      .storeData (storeData),
      .storeMask (storeMask)
   );

endmodule

//--- testbench/tb_core.sv
// Testbench for rv_core with a 1K-word memory and random busy cycles
// Programs and expected memory words come from testbench/core_vectors.mem
// A store of 1 to address 0xFFC ends each run
`timescale 1ns/1ps

module tb_core;

   localparam int MEM_WORDS = 1024;
   localparam int MAX_BUSY  = 3;
   localparam int CLK_NS    = 20;

   logic clk;
   logic resetn;
   rv_pkg::memReq_t memReq;
   rv_pkg::memRsp_t memRsp = '0;

   logic [31:0] mem [MEM_WORDS];
   logic [31:0] expAddr [$];
   logic [31:0] expData [$];
   logic [31:0] lcgState = 32'hb4e807f5;
   int          nVectors;
   logic        loaded = 1'b0;
   logic        done = 1'b0;
   int          rCnt = 0;
   int          wCnt = 0;
   int          protoErrors = 0;
   int          dataErrors = 0;
   logic [1:0]  delay;

   rv_core dut_i (
      .clk    (clk),
      .resetn (resetn),
      .memReq (memReq),
      .memRsp (memRsp)
   );

   initial begin
      clk = 1'b0;
      forever #(CLK_NS / 2) clk = ~clk;
   end

   // Linear congruential step
   function automatic logic [31:0] lcgNext(input logic [31:0] s);
      return s * 32'd1664525 + 32'd1013904223;
   endfunction

   // Fill memory, then apply P lines and queue E lines
   task automatic loadVectors();
      int          fd;
      int          n;
      string       line;
      byte         tag;
      logic [31:0] a;
      logic [31:0] d;
      for (int i = 0; i < MEM_WORDS; i++) begin
         mem[i] = (i * 32'h9E3779B1) ^ 32'h5A5A5A5A;
      end
      nVectors = 0;
      fd = $fopen("testbench/core_vectors.mem", "r");
      if (fd == 0) begin
         $display("Cannot open the vector file testbench/core_vectors.mem");
         return;
      end
      while (!$feof(fd)) begin
         n = $fgets(line, fd);
         if (n != 0 && $sscanf(line, "%c %h %h", tag, a, d) == 3) begin
            nVectors++;
            if (tag == "P") begin
               mem[a[11:2]] = d;
            end else if (tag == "E") begin
               expAddr.push_back(a);
               expData.push_back(d);
            end
         end
      end
      $fclose(fd);
   endtask

   // Memory model driving its responses on the falling edge
   always @(negedge clk) begin
      if (resetn) begin
         if (memReq.rstrb && memReq.wstrb) begin
            $display("Protocol error at %0t: read and write strobes high together", $time);
            protoErrors++;
         end
         if ((memReq.rstrb || memReq.wstrb) && (memRsp.rbusy || memRsp.wbusy)) begin
            $display("Protocol error at %0t: strobe raised while memory still busy", $time);
            protoErrors++;
         end
         // Read side
         if (memReq.rstrb) begin
            lcgState = lcgNext(lcgState);
            delay = lcgState[31:30];
            memRsp.rdata = mem[memReq.addr[11:2]];
            rCnt = delay;
            memRsp.rbusy = (delay != 0);
         end else begin
            if (rCnt != 0) begin
               rCnt--;
            end
            memRsp.rbusy = (rCnt != 0);
         end
         // Write side writes only the lanes under the mask
         if (memReq.wstrb) begin
            for (int b = 0; b < 4; b++) begin
               if (memReq.mask[b]) begin
                  mem[memReq.addr[11:2]][8*b +: 8] = memReq.wdata[8*b +: 8];
               end
            end
            if (memReq.addr[11:2] == 10'h3FF && memReq.wdata == 32'd1) begin
               done = 1'b1;
            end
            lcgState = lcgNext(lcgState);
            delay = lcgState[31:30];
            wCnt = delay;
            memRsp.wbusy = (delay != 0);
         end else begin
            if (wCnt != 0) begin
               wCnt--;
            end
            memRsp.wbusy = (wCnt != 0);
         end
      end
   end

   // Watchdog scaled by the vector count and the worst busy delay
   initial begin
      longint limitNs;
      wait (loaded);
      limitNs = (longint'(nVectors) * 8 * MAX_BUSY + 16) * CLK_NS;
      #(limitNs);
      $display("Timeout: no end-of-program store after %0d ns", limitNs);
      $display("TEST FAILED");
      $finish;
   end

   initial begin
      int total;
      resetn = 1'b0;
      loadVectors();
      loaded = 1'b1;
      repeat (16) @(negedge clk);
      resetn = 1'b1;
      if (nVectors == 0) begin
         $display("No vectors were read");
         dataErrors++;
      end else begin
         wait (done);
         @(negedge clk);
         foreach (expAddr[i]) begin
            if (mem[expAddr[i][11:2]] !== expData[i]) begin
               $display("FAILED t=%0t addr=%h expected=%h actual=%h",
                        $time, expAddr[i], expData[i], mem[expAddr[i][11:2]]);
               dataErrors++;
            end
         end
      end
      total = dataErrors + protoErrors;
      $display("Checks done: %0d errors (%0d data, %0d protocol)",
               total, dataErrors, protoErrors);
      if (total == 0) begin
         $display("TEST OK");
      end else begin
         $display("TEST FAILED");
      end
      $finish;
   end

endmodule

//--- testbench/core_vectors.mem
// Columns: tag (P program/data word, E expected final word), byte address, word
// ALU ops
P 00000000 FFB00093
P 00000004 00300113
P 00000008 40000513
P 0000000C 402081B3
P 00000010 00352023
P 00000014 4020D233
P 00000018 00452223
P 0000001C 0020D2B3
P 00000020 00552423
P 00000024 00209333
P 00000028 00652623
P 0000002C 0020A3B3
P 00000030 00752823
P 00000034 0020B433
P 00000038 00852A23
P 0000003C 00000593
// Branches, each skips one marker ori
P 00000040 00208463
P 00000044 0015E593
P 00000048 00108463
P 0000004C 0025E593
P 00000050 00209463
P 00000054 0045E593
P 00000058 00109463
P 0000005C 0085E593
P 00000060 0020C463
P 00000064 0105E593
P 00000068 00114463
P 0000006C 0205E593
P 00000070 00115463
P 00000074 0405E593
P 00000078 0020D463
P 0000007C 0805E593
P 00000080 00116463
P 00000084 1005E593
P 00000088 0020E463
P 0000008C 2005E593
P 00000090 0020F463
P 00000094 4005E593
P 00000098 00117463
P 0000009C 8005E593
P 000000A0 00B52C23
// Jumps, LUI, AUIPC, x0
P 000000A4 0080076F
P 000000A8 00000713
P 000000AC 00C707E7
P 000000B0 00000793
P 000000B4 00E52E23
P 000000B8 02F52023
P 000000BC 12345837
P 000000C0 03052223
P 000000C4 00001897
P 000000C8 03152423
P 000000CC 00500013
P 000000D0 02052623
// Loads from 0x460, each stored
P 000000D4 06050603
P 000000D8 02C52823
P 000000DC 06150603
P 000000E0 02C52A23
P 000000E4 06250603
P 000000E8 02C52C23
P 000000EC 06350603
P 000000F0 02C52E23
P 000000F4 06254603
P 000000F8 04C52023
P 000000FC 06051603
P 00000100 04C52223
P 00000104 06251603
P 00000108 04C52423
P 0000010C 06255603
P 00000110 04C52623
// Byte and halfword stores, then the end store and a self loop
P 00000114 06650823
P 00000118 066509A3
P 0000011C 06650AA3
P 00000120 06650B23
P 00000124 06651D23
P 00000128 06651E23
P 0000012C 00100913
P 00000130 FF202E23
P 00000134 0000006F
// Data words
P 00000460 80F17F01
P 00000470 11223344
P 00000474 55667788
P 00000478 99AABBCC
P 0000047C DDEEFF00
// Expected results
E 00000400 FFFFFFF8
E 00000404 FFFFFFFF
E 00000408 1FFFFFFF
E 0000040C FFFFFFD8
E 00000410 00000001
E 00000414 00000000
E 00000418 FFFFFAA9
E 0000041C 000000A8
E 00000420 000000B0
E 00000424 12345000
E 00000428 000010C4
E 0000042C 00000000
E 00000430 00000001
E 00000434 0000007F
E 00000438 FFFFFFF1
E 0000043C FFFFFF80
E 00000440 000000F1
E 00000444 00007F01
E 00000448 FFFF80F1
E 0000044C 000080F1
E 00000460 80F17F01
E 00000470 D82233D8
E 00000474 55D8D888
E 00000478 FFD8BBCC
E 0000047C DDEEFFD8
E 00000FFC 00000001

//--- files.f
+incdir+verilog
verilog/rv_pkg.sv
verilog/rv_decoder.sv
verilog/rv_alu.sv
verilog/rv_regfile.sv
verilog/rv_lsu.sv
verilog/rv_control.sv
verilog/rv_core.sv
testbench/tb_core.sv

//--- Makefile
VERILATOR = verilator
FLAGS     = --binary --timing --assert -Wno-fatal
TOP       = tb_core
FILELIST  = files.f

.PHONY: sim clean

sim:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	@out=$$(./obj_dir/V$(TOP)); echo "$$out"; echo "$$out" | grep -q "^TEST OK$$"

clean:
	rm -rf obj_dir
